// ==== design/avst2axis.sv ====
// --------------------------------------------------------------------------
// RX converter from Avalon-ST beats to registered AXI-Stream beats.
// --------------------------------------------------------------------------
`default_nettype none

module avst2axis #(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_avst_valid,
    input  eth_mac_pkg::mac_data_t  i_avst_data,
    input  logic                    i_avst_sop,
    input  logic                    i_avst_eop,
    input  eth_mac_pkg::mac_empty_t i_avst_empty,
    input  logic [5:0]              i_avst_error,
    output eth_mac_pkg::mac_data_t  o_axis_tdata,
    output eth_mac_pkg::mac_keep_t  o_axis_tkeep,
    output logic                    o_axis_tvalid,
    output logic                    o_axis_tlast,
    output logic                    o_axis_tuser
);

    logic                   in_frame;
    logic                   accept;             // beat belongs to a frame.
    eth_mac_pkg::mac_keep_t eop_keep;

    // beats outside a frame, with no sop to open one, are dropped.
    assign accept   = i_avst_valid && (i_avst_sop || in_frame);
    assign eop_keep = eth_mac_pkg::mac_keep_t'('1) >> i_avst_empty;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            in_frame      <= 1'b0;
            o_axis_tvalid <= 1'b0;
        end else begin
            o_axis_tvalid <= accept;
            if (accept) begin
                in_frame <= !i_avst_eop;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_axis_tdata <= BYTE_REVERSE ? eth_mac_pkg::byte_swap(i_avst_data)
                                         : i_avst_data;
            o_axis_tkeep <= i_avst_eop ? eop_keep : '1;
            o_axis_tlast <= i_avst_eop;
            o_axis_tuser <= i_avst_eop & (|i_avst_error);   // any mac error marks the frame.
        end
    end

endmodule

`default_nettype wire

// ==== design/axis2avst.sv ====
// --------------------------------------------------------------------------
// TX converter from AXI-Stream beats to Avalon-ST beats.
// --------------------------------------------------------------------------
`default_nettype none

module axis2avst #(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  eth_mac_pkg::mac_data_t  i_axis_tdata,
    input  eth_mac_pkg::mac_keep_t  i_axis_tkeep,
    input  logic                    i_axis_tvalid,
    input  logic                    i_axis_tlast,
    input  logic                    i_axis_tuser,
    output logic                    o_axis_tready,
    input  logic                    i_avst_ready,
    output logic                    o_avst_valid,
    output eth_mac_pkg::mac_data_t  o_avst_data,
    output logic                    o_avst_sop,
    output logic                    o_avst_eop,
    output eth_mac_pkg::mac_empty_t o_avst_empty,
    output logic                    o_avst_error
);

    logic       in_frame;                       // set after the first beat of a frame.
    logic [3:0] unused_bytes;

    // keep is contiguous from byte 0, so zero bits count the empty tail.
    always_comb begin
        unused_bytes = '0;
        for (int i = 0; i < eth_mac_pkg::MAC_KEEP_W; i++) begin
            unused_bytes = unused_bytes + {3'b000, ~i_axis_tkeep[i]};
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            in_frame <= 1'b0;
        end else if (i_axis_tvalid && i_avst_ready) begin
            in_frame <= !i_axis_tlast;
        end
    end

    assign o_axis_tready = i_avst_ready;        // no buffering, ready passes through.
    assign o_avst_valid  = i_axis_tvalid;
    assign o_avst_data   = BYTE_REVERSE ? eth_mac_pkg::byte_swap(i_axis_tdata)
                                        : i_axis_tdata;
    assign o_avst_sop    = !in_frame;
    assign o_avst_eop    = i_axis_tlast;
    assign o_avst_empty  = i_axis_tlast ? eth_mac_pkg::mac_empty_t'(unused_bytes) : '0;
    assign o_avst_error  = i_axis_tlast & i_axis_tuser;

endmodule

`default_nettype wire

// ==== design/eth_mac_adapter.sv ====
// --------------------------------------------------------------------------
// Ethernet MAC adapter top: TX and RX stream converters, reset sync and
// transceiver reconfiguration sequencer.
// --------------------------------------------------------------------------
`default_nettype none

module eth_mac_adapter #(
    parameter int RST_SYNC_STAGES = 4,
    parameter bit BYTE_REVERSE    = 1'b1
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_pll_locked,
    output logic                    o_mac_rst,

    input  eth_mac_pkg::mac_data_t  i_tx_axis_tdata,
    input  eth_mac_pkg::mac_keep_t  i_tx_axis_tkeep,
    input  logic                    i_tx_axis_tvalid,
    input  logic                    i_tx_axis_tlast,
    input  logic                    i_tx_axis_tuser,
    output logic                    o_tx_axis_tready,

    input  logic                    i_tx_avst_ready,
    output logic                    o_tx_avst_valid,
    output eth_mac_pkg::mac_data_t  o_tx_avst_data,
    output logic                    o_tx_avst_sop,
    output logic                    o_tx_avst_eop,
    output eth_mac_pkg::mac_empty_t o_tx_avst_empty,
    output logic                    o_tx_avst_error,

    input  logic                    i_rx_avst_valid,
    input  eth_mac_pkg::mac_data_t  i_rx_avst_data,
    input  logic                    i_rx_avst_sop,
    input  logic                    i_rx_avst_eop,
    input  eth_mac_pkg::mac_empty_t i_rx_avst_empty,
    input  logic [5:0]              i_rx_avst_error,

    output eth_mac_pkg::mac_data_t  o_rx_axis_tdata,
    output eth_mac_pkg::mac_keep_t  o_rx_axis_tkeep,
    output logic                    o_rx_axis_tvalid,
    output logic                    o_rx_axis_tlast,
    output logic                    o_rx_axis_tuser,

    output eth_mac_pkg::rcfg_addr_t o_rcfg_address,
    output logic                    o_rcfg_read,
    output logic                    o_rcfg_write,
    output eth_mac_pkg::rcfg_data_t o_rcfg_writedata,
    input  eth_mac_pkg::rcfg_data_t i_rcfg_readdata,
    input  logic                    i_rcfg_waitrequest,
    output logic                    o_rcfg_done
);

    logic mac_rst_n;                            // datapath reset after lock.

    mac_reset_sync #(
        .STAGES       (RST_SYNC_STAGES)
    ) u_mac_reset_sync (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_pll_locked (i_pll_locked),
        .o_mac_rst    (o_mac_rst),
        .o_mac_rst_n  (mac_rst_n)
    );

    // control side runs from the system reset, not the MAC reset.
    xcvr_ctrl u_xcvr_ctrl (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_pll_locked       (i_pll_locked),
        .o_rcfg_address     (o_rcfg_address),
        .o_rcfg_read        (o_rcfg_read),
        .o_rcfg_write       (o_rcfg_write),
        .o_rcfg_writedata   (o_rcfg_writedata),
        .i_rcfg_readdata    (i_rcfg_readdata),
        .i_rcfg_waitrequest (i_rcfg_waitrequest),
        .o_rcfg_done        (o_rcfg_done)
    );

    axis2avst #(
        .BYTE_REVERSE  (BYTE_REVERSE)
    ) u_tx_axis2avst (
        .i_clk         (i_clk),
        .i_arst_n      (mac_rst_n),
        .i_axis_tdata  (i_tx_axis_tdata),
        .i_axis_tkeep  (i_tx_axis_tkeep),
        .i_axis_tvalid (i_tx_axis_tvalid),
        .i_axis_tlast  (i_tx_axis_tlast),
        .i_axis_tuser  (i_tx_axis_tuser),
        .o_axis_tready (o_tx_axis_tready),
        .i_avst_ready  (i_tx_avst_ready),
        .o_avst_valid  (o_tx_avst_valid),
        .o_avst_data   (o_tx_avst_data),
        .o_avst_sop    (o_tx_avst_sop),
        .o_avst_eop    (o_tx_avst_eop),
        .o_avst_empty  (o_tx_avst_empty),
        .o_avst_error  (o_tx_avst_error)
    );

    avst2axis #(
        .BYTE_REVERSE  (BYTE_REVERSE)
    ) u_rx_avst2axis (
        .i_clk         (i_clk),
        .i_arst_n      (mac_rst_n),
        .i_avst_valid  (i_rx_avst_valid),
        .i_avst_data   (i_rx_avst_data),
        .i_avst_sop    (i_rx_avst_sop),
        .i_avst_eop    (i_rx_avst_eop),
        .i_avst_empty  (i_rx_avst_empty),
        .i_avst_error  (i_rx_avst_error),
        .o_axis_tdata  (o_rx_axis_tdata),
        .o_axis_tkeep  (o_rx_axis_tkeep),
        .o_axis_tvalid (o_rx_axis_tvalid),
        .o_axis_tlast  (o_rx_axis_tlast),
        .o_axis_tuser  (o_rx_axis_tuser)
    );

endmodule

`default_nettype wire

// ==== design/eth_mac_pkg.sv ====
// --------------------------------------------------------------------------
// Ethernet MAC adapter package: beat widths, types and the transceiver
// reconfiguration table.
// --------------------------------------------------------------------------
`default_nettype none

package eth_mac_pkg;

    localparam int MAC_DATA_W  = 64;
    localparam int MAC_KEEP_W  = 8;             // one enable per data byte.
    localparam int MAC_EMPTY_W = 3;

    typedef logic [MAC_DATA_W-1:0]  mac_data_t;
    typedef logic [MAC_KEEP_W-1:0]  mac_keep_t;
    typedef logic [MAC_EMPTY_W-1:0] mac_empty_t;

    localparam int RCFG_ADDR_W = 19;
    localparam int RCFG_DATA_W = 8;

    typedef logic [RCFG_ADDR_W-1:0] rcfg_addr_t;
    typedef logic [RCFG_DATA_W-1:0] rcfg_data_t;

    localparam int RCFG_LEN = 4;

    // rmw entries keep the old value outside the mask and or in the data.
    localparam rcfg_addr_t RCFG_ADDR [0:RCFG_LEN-1] = '{19'h00004, 19'h00011,
                                                        19'h00026, 19'h00033};
    localparam rcfg_data_t RCFG_DATA [0:RCFG_LEN-1] = '{8'h5a, 8'h04, 8'h30, 8'h81};
    localparam rcfg_data_t RCFG_MASK [0:RCFG_LEN-1] = '{8'hff, 8'h0c, 8'hf0, 8'h81};
    localparam bit         RCFG_RMW  [0:RCFG_LEN-1] = '{1'b0, 1'b1, 1'b1, 1'b0};

    // mirrors byte order, byte 0 swaps with the top byte.
    function automatic mac_data_t byte_swap(input mac_data_t d);
        mac_data_t r;
        for (int i = 0; i < MAC_KEEP_W; i++) begin
            r[i*8 +: 8] = d[(MAC_KEEP_W-1-i)*8 +: 8];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== design/mac_reset_sync.sv ====
// --------------------------------------------------------------------------
// MAC reset synchronizer, held until PLL lock and system reset both release.
// --------------------------------------------------------------------------
`default_nettype none

module mac_reset_sync #(
    parameter int STAGES = 4
) (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_pll_locked,
    output logic o_mac_rst,
    output logic o_mac_rst_n
);

    logic              rel_n;                   // low while either source holds reset.
    logic [STAGES-1:0] sync_chain;

    assign rel_n = i_arst_n & i_pll_locked;

    // assert at once, release through the chain.
    always_ff @(posedge i_clk or negedge rel_n) begin
        if (!rel_n) begin
            sync_chain <= '0;
        end else begin
            sync_chain <= {sync_chain[STAGES-2:0], 1'b1};
        end
    end

    assign o_mac_rst_n = sync_chain[STAGES-1];
    assign o_mac_rst   = ~sync_chain[STAGES-1];   // toward the MAC core.

endmodule

`default_nettype wire

// ==== design/xcvr_ctrl.sv ====
// --------------------------------------------------------------------------
// Transceiver control sequencer, walks the reconfiguration table after lock.
// --------------------------------------------------------------------------
`default_nettype none

module xcvr_ctrl (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_pll_locked,
    output eth_mac_pkg::rcfg_addr_t o_rcfg_address,
    output logic                    o_rcfg_read,
    output logic                    o_rcfg_write,
    output eth_mac_pkg::rcfg_data_t o_rcfg_writedata,
    input  eth_mac_pkg::rcfg_data_t i_rcfg_readdata,
    input  logic                    i_rcfg_waitrequest,
    output logic                    o_rcfg_done
);

    localparam int IDX_W = $clog2(eth_mac_pkg::RCFG_LEN);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_NEXT,
        ST_DONE
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;                      // current table entry.
    logic             lock_meta;
    logic             lock_sync;
    logic             last_entry;

    assign last_entry     = (idx == IDX_W'(eth_mac_pkg::RCFG_LEN - 1));
    assign o_rcfg_address = eth_mac_pkg::RCFG_ADDR[idx];   // idx holds during a request.

    // lock comes from the PLL domain.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lock_meta <= 1'b0;
            lock_sync <= 1'b0;
        end else begin
            lock_meta <= i_pll_locked;
            lock_sync <= lock_meta;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state        <= ST_IDLE;
            idx          <= '0;
            o_rcfg_read  <= 1'b0;
            o_rcfg_write <= 1'b0;
            o_rcfg_done  <= 1'b0;
        end else if (!lock_sync) begin
            state        <= ST_IDLE;                // start over on the next lock.
            idx          <= '0;
            o_rcfg_read  <= 1'b0;
            o_rcfg_write <= 1'b0;
            o_rcfg_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    idx   <= '0;
                    state <= ST_NEXT;
                end
                ST_NEXT: begin
                    if (eth_mac_pkg::RCFG_RMW[idx]) begin
                        o_rcfg_read <= 1'b1;
                        state       <= ST_READ;
                    end else begin
                        o_rcfg_write <= 1'b1;
                        state        <= ST_WRITE;
                    end
                end
                ST_READ: begin
                    if (!i_rcfg_waitrequest) begin
                        o_rcfg_read  <= 1'b0;
                        o_rcfg_write <= 1'b1;   // merged value is ready now.
                        state        <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (!i_rcfg_waitrequest) begin
                        o_rcfg_write <= 1'b0;
                        if (last_entry) begin
                            o_rcfg_done <= 1'b1;
                            state       <= ST_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= ST_NEXT;
                        end
                    end
                end
                ST_DONE: state <= ST_DONE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_NEXT) begin
            o_rcfg_writedata <= eth_mac_pkg::RCFG_DATA[idx];
        end else if (state == ST_READ && !i_rcfg_waitrequest) begin
            o_rcfg_writedata <= (i_rcfg_readdata & ~eth_mac_pkg::RCFG_MASK[idx])
                              | eth_mac_pkg::RCFG_DATA[idx];
        end
    end

endmodule

`default_nettype wire

// ==== eth_mac_adapter.f ====
design/eth_mac_pkg.sv
design/mac_reset_sync.sv
design/xcvr_ctrl.sv
design/axis2avst.sv
design/avst2axis.sv
design/eth_mac_adapter.sv
tb/eth_mac_checker.sv
tb/eth_mac_scoreboard.sv
tb/tb_eth_mac_adapter.sv

// ==== tb/eth_mac_checker.sv ====
// --------------------------------------------------------------------------
// Handshake assertions for the Ethernet MAC adapter, bound into the DUT.
// --------------------------------------------------------------------------
`default_nettype none

module eth_mac_checker (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_tx_avst_ready,
    input  logic                    o_tx_avst_valid,
    input  eth_mac_pkg::mac_data_t  o_tx_avst_data,
    input  logic                    o_rcfg_read,
    input  logic                    o_rcfg_write,
    input  eth_mac_pkg::rcfg_addr_t o_rcfg_address,
    input  eth_mac_pkg::rcfg_data_t o_rcfg_writedata,
    input  logic                    i_rcfg_waitrequest
);

    int fail_count = 0;                         // read by the testbench top at the end.

    tx_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_tx_avst_valid && !i_tx_avst_ready |=> o_tx_avst_valid && $stable(o_tx_avst_data))
    else begin
        fail_count++;
        $error("tx beat dropped or changed while the MAC held ready low");
    end

    // address and write data must not move until the slave accepts.
    rcfg_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_rcfg_read || o_rcfg_write) && i_rcfg_waitrequest
        |=> $stable({o_rcfg_read, o_rcfg_write, o_rcfg_address, o_rcfg_writedata}))
    else begin
        fail_count++;
        $error("reconfiguration request changed while waitrequest was high");
    end

    rcfg_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_rcfg_read && o_rcfg_write))
    else begin
        fail_count++;
        $error("reconfiguration read and write were high together");
    end

endmodule

bind eth_mac_adapter eth_mac_checker u_checker (.*);

`default_nettype wire

// ==== tb/eth_mac_scoreboard.sv ====
// --------------------------------------------------------------------------
// Scoreboard for the Ethernet MAC adapter: reference models for the TX, RX
// and reconfiguration paths, compared against the DUT every clock.
// --------------------------------------------------------------------------
`default_nettype none

module eth_mac_scoreboard #(
    parameter int STAGES       = 4,
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_pll_locked,
    input  logic                    o_mac_rst,
    input  eth_mac_pkg::mac_data_t  i_tx_axis_tdata,
    input  eth_mac_pkg::mac_keep_t  i_tx_axis_tkeep,
    input  logic                    i_tx_axis_tvalid,
    input  logic                    i_tx_axis_tlast,
    input  logic                    i_tx_axis_tuser,
    input  logic                    o_tx_axis_tready,
    input  logic                    i_tx_avst_ready,
    input  logic                    o_tx_avst_valid,
    input  eth_mac_pkg::mac_data_t  o_tx_avst_data,
    input  logic                    o_tx_avst_sop,
    input  logic                    o_tx_avst_eop,
    input  eth_mac_pkg::mac_empty_t o_tx_avst_empty,
    input  logic                    o_tx_avst_error,
    input  logic                    i_rx_avst_valid,
    input  eth_mac_pkg::mac_data_t  i_rx_avst_data,
    input  logic                    i_rx_avst_eop,
    input  eth_mac_pkg::mac_empty_t i_rx_avst_empty,
    input  logic [5:0]              i_rx_avst_error,
    input  eth_mac_pkg::mac_data_t  o_rx_axis_tdata,
    input  eth_mac_pkg::mac_keep_t  o_rx_axis_tkeep,
    input  logic                    o_rx_axis_tvalid,
    input  logic                    o_rx_axis_tlast,
    input  logic                    o_rx_axis_tuser,
    input  logic                    o_rcfg_read,
    input  logic                    o_rcfg_write,
    input  logic                    o_rcfg_done,
    input  logic [63:0][7:0]        i_slave_mem
);

    int   tx_errors    = 0;
    int   rx_errors    = 0;
    int   rcfg_errors  = 0;
    int   rst_errors   = 0;
    int   tx_frames    = 0;
    int   rx_frames    = 0;
    int   rel_cycles   = 0;                     // cycles since reset and lock both released.
    logic tx_first     = 1'b1;
    logic rcfg_checked = 1'b0;
    logic exp_rx_valid = 1'b0;
    logic exp_rx_last;
    logic exp_rx_user;
    eth_mac_pkg::mac_data_t exp_rx_data;
    eth_mac_pkg::mac_keep_t exp_rx_keep;
    logic [63:0][7:0]       init_mem;
    logic [63:0][7:0]       exp_mem;

    function automatic eth_mac_pkg::mac_data_t reverse_bytes(input eth_mac_pkg::mac_data_t d);
        eth_mac_pkg::mac_data_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return BYTE_REVERSE ? r : d;
    endfunction

    function automatic logic [2:0] empty_of_keep(input logic [7:0] keep);
        int n = 0;
        for (int i = 0; i < 8; i++) begin
            if (!keep[i]) n++;
        end
        return 3'(n);
    endfunction

    // valid bytes sit at the low end of the word.
    function automatic logic [7:0] keep_of_empty(input logic [2:0] empty);
        logic [7:0] k;
        for (int i = 0; i < 8; i++) begin
            k[i] = (i < 8 - empty);
        end
        return k;
    endfunction

    function automatic logic [7:0] rcfg_result(input logic [7:0] old, input int k);
        if (eth_mac_pkg::RCFG_RMW[k]) begin
            return (old & ~eth_mac_pkg::RCFG_MASK[k]) | eth_mac_pkg::RCFG_DATA[k];
        end
        return eth_mac_pkg::RCFG_DATA[k];
    endfunction

    function automatic int mismatch(input string what, input logic [63:0] exp,
                                    input logic [63:0] got);
        if (exp === got) return 0;
        $display("[ERROR] %0t: %s expected %0h, got %0h", $time, what, exp, got);
        return 1;
    endfunction

    always @(posedge i_clk) begin
        if (!(i_arst_n && i_pll_locked)) begin
            rel_cycles = 0;
            rst_errors += mismatch("mac reset before lock", 1, o_mac_rst);
        end else begin
            rel_cycles++;
            if (rel_cycles > STAGES) rst_errors += mismatch("mac reset after lock", 0, o_mac_rst);
        end
        if (!i_arst_n) begin
            init_mem = i_slave_mem;             // preload is stable during reset.
            rst_errors += mismatch("control outputs in reset", 0, {o_tx_avst_valid,
                o_rx_axis_tvalid, o_rcfg_read, o_rcfg_write, o_rcfg_done});
        end

        tx_errors += mismatch("tx ready", i_tx_avst_ready, o_tx_axis_tready);
        tx_errors += mismatch("tx valid", i_tx_axis_tvalid, o_tx_avst_valid);
        if (i_tx_axis_tvalid) begin
            tx_errors += mismatch("tx data", reverse_bytes(i_tx_axis_tdata), o_tx_avst_data);
            tx_errors += mismatch("tx sop", tx_first, o_tx_avst_sop);
            tx_errors += mismatch("tx eop", i_tx_axis_tlast, o_tx_avst_eop);
            if (i_tx_axis_tlast) begin
                tx_errors += mismatch("tx empty", empty_of_keep(i_tx_axis_tkeep), o_tx_avst_empty);
                tx_errors += mismatch("tx error", i_tx_axis_tuser, o_tx_avst_error);
            end
            if (i_tx_avst_ready) tx_first = i_tx_axis_tlast;
        end
        if (o_tx_avst_valid && i_tx_avst_ready && o_tx_avst_eop) tx_frames++;

        // rx output lags its input by one clock.
        rx_errors += mismatch("rx valid", exp_rx_valid, o_rx_axis_tvalid);
        if (exp_rx_valid) begin
            rx_errors += mismatch("rx data", exp_rx_data, o_rx_axis_tdata);
            rx_errors += mismatch("rx keep", exp_rx_keep, o_rx_axis_tkeep);
            rx_errors += mismatch("rx last", exp_rx_last, o_rx_axis_tlast);
            rx_errors += mismatch("rx user", exp_rx_user, o_rx_axis_tuser);
        end
        if (o_rx_axis_tvalid && o_rx_axis_tlast) rx_frames++;
        exp_rx_valid = i_rx_avst_valid && (rel_cycles > STAGES);
        exp_rx_data  = reverse_bytes(i_rx_avst_data);
        exp_rx_keep  = i_rx_avst_eop ? keep_of_empty(i_rx_avst_empty) : 8'hff;
        exp_rx_last  = i_rx_avst_eop;
        exp_rx_user  = i_rx_avst_eop && (i_rx_avst_error != 0);

        if (o_rcfg_done && !rcfg_checked) begin
            exp_mem = init_mem;
            for (int k = 0; k < eth_mac_pkg::RCFG_LEN; k++) begin
                exp_mem[eth_mac_pkg::RCFG_ADDR[k][5:0]] =
                    rcfg_result(exp_mem[eth_mac_pkg::RCFG_ADDR[k][5:0]], k);
            end
            for (int a = 0; a < 64; a++) begin
                rcfg_errors += mismatch($sformatf("slave byte %0d", a), exp_mem[a], i_slave_mem[a]);
            end
            rcfg_checked = 1'b1;
        end
    end

    task automatic final_check(input int tx_sent, input int rx_sent);
        tx_errors += mismatch("tx frame count", tx_sent, tx_frames);
        rx_errors += mismatch("rx frame count", rx_sent, rx_frames);
        if (!rcfg_checked) begin
            $display("reconfiguration never finished, done did not rise");
            rcfg_errors++;
        end
    endtask

endmodule

`default_nettype wire

// ==== tb/tb_eth_mac_adapter.sv ====
// --------------------------------------------------------------------------
// Testbench for the Ethernet MAC adapter with TX and RX frame traffic and an
// Avalon-MM slave model on the reconfiguration port.
// --------------------------------------------------------------------------
`default_nettype none

module tb_eth_mac_adapter;

    localparam int RST_STAGES  = 4;
    localparam bit BYTE_REV    = 1'b1;
    localparam int FRAMES      = 10;            // per traffic phase.
    localparam int MAX_BEATS   = 6;
    // three phases of longest frames, four times over for back-pressure and gaps.
    localparam int CYCLE_LIMIT = 3 * FRAMES * MAX_BEATS * 4 + 300;

    logic                    i_clk;
    logic                    i_arst_n;
    logic                    i_pll_locked;
    logic                    o_mac_rst;
    eth_mac_pkg::mac_data_t  i_tx_axis_tdata;
    eth_mac_pkg::mac_keep_t  i_tx_axis_tkeep;
    logic                    i_tx_axis_tvalid;
    logic                    i_tx_axis_tlast;
    logic                    i_tx_axis_tuser;
    logic                    o_tx_axis_tready;
    logic                    i_tx_avst_ready;
    logic                    o_tx_avst_valid;
    eth_mac_pkg::mac_data_t  o_tx_avst_data;
    logic                    o_tx_avst_sop;
    logic                    o_tx_avst_eop;
    eth_mac_pkg::mac_empty_t o_tx_avst_empty;
    logic                    o_tx_avst_error;
    logic                    i_rx_avst_valid;
    eth_mac_pkg::mac_data_t  i_rx_avst_data;
    logic                    i_rx_avst_sop;
    logic                    i_rx_avst_eop;
    eth_mac_pkg::mac_empty_t i_rx_avst_empty;
    logic [5:0]              i_rx_avst_error;
    eth_mac_pkg::mac_data_t  o_rx_axis_tdata;
    eth_mac_pkg::mac_keep_t  o_rx_axis_tkeep;
    logic                    o_rx_axis_tvalid;
    logic                    o_rx_axis_tlast;
    logic                    o_rx_axis_tuser;
    eth_mac_pkg::rcfg_addr_t o_rcfg_address;
    logic                    o_rcfg_read;
    logic                    o_rcfg_write;
    eth_mac_pkg::rcfg_data_t o_rcfg_writedata;
    eth_mac_pkg::rcfg_data_t i_rcfg_readdata;
    logic                    i_rcfg_waitrequest;
    logic                    o_rcfg_done;

    logic [63:0][7:0] slave_mem;                // indexed by the low address bits.
    logic             ready_random;
    int               seed = 33;
    int               cycle_count;
    int               tx_frames_sent;
    int               rx_frames_sent;
    int               total_errors;

    eth_mac_adapter #(
        .RST_SYNC_STAGES (RST_STAGES),
        .BYTE_REVERSE    (BYTE_REV)
    ) DUT (.*);

    eth_mac_scoreboard #(
        .STAGES       (RST_STAGES),
        .BYTE_REVERSE (BYTE_REV)
    ) u_scoreboard (.*, .i_slave_mem(slave_mem));

    assign i_rcfg_readdata = slave_mem[o_rcfg_address[5:0]];   // read data valid at once.

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        if (o_rcfg_write && !i_rcfg_waitrequest) begin
            slave_mem[o_rcfg_address[5:0]] <= o_rcfg_writedata;
        end
        #2;
        i_rcfg_waitrequest = ($random(seed) % 2) != 0;
        i_tx_avst_ready    = ready_random ? (($random(seed) % 2) != 0) : 1'b1;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic send_tx_frame(input int beats);
        for (int b = 0; b < beats; b++) begin
            i_tx_axis_tdata  = {$random(seed), $random(seed)};
            i_tx_axis_tkeep  = (b == beats - 1) ? 8'hff >> ({$random(seed)} % 8) : 8'hff;
            i_tx_axis_tlast  = (b == beats - 1);
            i_tx_axis_tuser  = ($random(seed) % 2) != 0;
            i_tx_axis_tvalid = 1'b1;
            @(posedge i_clk);
            while (!o_tx_axis_tready) @(posedge i_clk);
            #2;
        end
        i_tx_axis_tvalid = 1'b0;
        tx_frames_sent++;
    endtask

    task automatic send_rx_frame(input int beats);
        for (int b = 0; b < beats; b++) begin
            i_rx_avst_valid = 1'b1;
            i_rx_avst_data  = {$random(seed), $random(seed)};
            i_rx_avst_sop   = (b == 0);
            i_rx_avst_eop   = (b == beats - 1);
            i_rx_avst_empty = i_rx_avst_eop ? 3'($random(seed)) : '0;
            i_rx_avst_error = (i_rx_avst_eop && ($random(seed) % 3) == 0) ? 6'($random(seed)) : '0;
            next_cycle();
        end
        i_rx_avst_valid = 1'b0;
        i_rx_avst_eop   = 1'b0;
        rx_frames_sent++;
        next_cycle();                           // idle gap between frames.
    endtask

    initial begin
        i_clk              = 1'b0;
        i_arst_n           = 1'b0;
        i_pll_locked       = 1'b0;
        i_tx_axis_tdata    = '0;
        i_tx_axis_tkeep    = '0;
        i_tx_axis_tvalid   = 1'b0;
        i_tx_axis_tlast    = 1'b0;
        i_tx_axis_tuser    = 1'b0;
        i_tx_avst_ready    = 1'b1;
        i_rx_avst_valid    = 1'b0;
        i_rx_avst_data     = '0;
        i_rx_avst_sop      = 1'b0;
        i_rx_avst_eop      = 1'b0;
        i_rx_avst_empty    = '0;
        i_rx_avst_error    = '0;
        i_rcfg_waitrequest = 1'b1;
        ready_random       = 1'b0;
        cycle_count        = 0;
        tx_frames_sent     = 0;
        rx_frames_sent     = 0;
        for (int a = 0; a < 64; a++) begin
            slave_mem[a] = 8'(a * 37) ^ 8'(seed);   // distinct value per address.
        end

        repeat (3) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;
        repeat (4) next_cycle();                // lock still low, MAC held in reset.
        i_pll_locked = 1'b1;
        @(posedge i_clk);
        while (o_mac_rst) @(posedge i_clk);
        #2;

        repeat (FRAMES) send_tx_frame(1 + {$random(seed)} % MAX_BEATS);
        ready_random = 1'b1;
        repeat (FRAMES) send_tx_frame(1 + {$random(seed)} % MAX_BEATS);
        ready_random = 1'b0;
        repeat (FRAMES) send_rx_frame(1 + {$random(seed)} % MAX_BEATS);
        while (!o_rcfg_done) next_cycle();
        repeat (3) next_cycle();

        u_scoreboard.final_check(tx_frames_sent, rx_frames_sent);
        total_errors = u_scoreboard.tx_errors + u_scoreboard.rx_errors
                     + u_scoreboard.rcfg_errors + u_scoreboard.rst_errors
                     + DUT.u_checker.fail_count;
        $display("errors: tx=%0d rx=%0d rcfg=%0d reset=%0d assertions=%0d",
                 u_scoreboard.tx_errors, u_scoreboard.rx_errors, u_scoreboard.rcfg_errors,
                 u_scoreboard.rst_errors, DUT.u_checker.fail_count);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
